// ==== common/ob_params.svh ====
`ifndef OB_PARAMS_SVH
`define OB_PARAMS_SVH

// Command uid width
`define OB_UID_W 8

// Price in ticks
`define OB_PRICE_W 12

// Order quantity
`define OB_QTY_W 10

// Entries held by each side of the book
`define OB_BOOK_DEPTH 4

// Reserved uid, marks a trade response
`define OB_TRADE_UID {`OB_UID_W{1'b1}}

`endif

// ==== common/ob_pkg.sv ====
`include "ob_params.svh"

package ob_pkg;

  // Basic words
  typedef logic [`OB_UID_W-1:0] uid_t;
  typedef logic [`OB_PRICE_W-1:0] price_t;
  typedef logic [`OB_QTY_W-1:0] quantity_t;

  // Command opcodes
  typedef enum logic [2:0] {
    Op_Nop       = 3'd0,
    Op_QryBidAsk = 3'd1,
    Op_Buy       = 3'd2,
    Op_Sell      = 3'd3,
    Op_PopTopBid = 3'd4,
    Op_PopTopAsk = 3'd5
  } opcode_t;

  // Response status
  typedef enum logic [2:0] {
    S_Okay   = 3'd0,
    S_Bad    = 3'd1,
    S_BadPop = 3'd2,
    S_Full   = 3'd3
  } status_t;

  // One resting order, also the Buy/Sell operand
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } entry_t;

  // Result word width, every view of the union is padded to this
  localparam int RESULT_W = $bits(entry_t);

  typedef struct packed {
    opcode_t opcode;
    uid_t    uid;
    entry_t  oprand;
  } cmd_t;

  // Spread query view
  typedef struct packed {
    logic [RESULT_W-2*`OB_PRICE_W-1:0] rsvd;
    price_t                            bid;
    price_t                            ask;
  } result_qrybidask_t;

  // Trade view
  typedef struct packed {
    logic [RESULT_W-2*`OB_UID_W-`OB_QTY_W-1:0] rsvd;
    uid_t                                      bid_uid;
    uid_t                                      ask_uid;
    quantity_t                                 quantity;
  } result_trade_t;

  // Same word, decoded by response kind
  typedef union packed {
    result_qrybidask_t qrybidask;
    entry_t            poptop;
    result_trade_t     trade;
  } result_u;

  typedef struct packed {
    uid_t    uid;
    status_t status;
    result_u result;
  } rsp_t;

  // Outcome of one head comparison
  typedef struct packed {
    logic      vld;
    logic      bid_consumed;
    logic      ask_consumed;
    uid_t      bid_uid;
    uid_t      ask_uid;
    quantity_t quantity;
    quantity_t remainder;
  } match_t;

  // Head of one book side
  typedef struct packed {
    logic   vld;
    logic   full;
    entry_t head;
  } book_head_t;

endpackage

// ==== book/ob_book_side.sv ====
`timescale 1ns/100ps
`include "ob_params.svh"

module ob_book_side #(
  // 1 keeps highest price first, 0 lowest first
  parameter bit IS_BID = 1'b1
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               insert,
  input  ob_pkg::entry_t     insert_entry,
  input  logic               pop,
  input  logic               update,
  input  ob_pkg::quantity_t  update_qty,
  output ob_pkg::book_head_t head
);
  import ob_pkg::*;

  localparam int DEPTH = `OB_BOOK_DEPTH;

  // Slot 0 is the head
  entry_t           mem [DEPTH];
  logic [DEPTH-1:0] vld_q;

  // Entries that stay in front of a new order
  logic [DEPTH-1:0] ahead;
  // Slot that takes the new order
  logic [DEPTH-1:0] slot_new;

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      // Equal price stays ahead, so older orders keep priority
      if (IS_BID) begin
        ahead[i] = vld_q[i] && (mem[i].price >= insert_entry.price);
      end else begin
        ahead[i] = vld_q[i] && (mem[i].price <= insert_entry.price);
      end
    end
    // ahead is a run from slot 0, the first miss gets the order
    slot_new = ~ahead & {ahead[DEPTH-2:0], 1'b1};
  end

  // Occupancy as a run of ones from slot 0
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else if (pop) begin
      vld_q <= {1'b0, vld_q[DEPTH-1:1]};
    end else if (insert && !update) begin
      vld_q <= {vld_q[DEPTH-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      // Shift toward the head, last slot goes stale
      for (int i = 0; i < DEPTH - 1; i++) begin
        mem[i] <= mem[i+1];
      end
    end else if (update) begin
      mem[0].quantity <= update_qty;
    end else if (insert) begin
      // New best order takes the head
      if (slot_new[0]) begin
        mem[0] <= insert_entry;
      end
      // Slots behind the new order move back one
      for (int i = 1; i < DEPTH; i++) begin
        if (!ahead[i]) begin
          mem[i] <= slot_new[i] ? insert_entry : mem[i-1];
        end
      end
    end
  end

  always_comb begin
    head.vld  = vld_q[0];
    head.full = vld_q[DEPTH-1];
    head.head = mem[0];
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> vld_q[0]);

  // Holds only if every earlier insert and pop kept the run intact
  a_vld_contiguous: assert property (@(posedge clk) disable iff (rst)
    ((vld_q + 1'b1) & vld_q) == '0);

endmodule

// ==== design/ob_match.sv ====
`timescale 1ns/100ps

module ob_match (
  input  logic               clk,
  input  logic               rst,
  input  ob_pkg::book_head_t bid_head,
  input  ob_pkg::book_head_t ask_head,
  input  logic               capture,
  output ob_pkg::match_t     match
);
  import ob_pkg::*;

  quantity_t bid_qty;
  quantity_t ask_qty;
  logic      bid_more;
  logic      ask_more;
  match_t    match_d;
  match_t    data_q;
  logic      vld_q;

  always_comb begin
    bid_qty  = bid_head.head.quantity;
    ask_qty  = ask_head.head.quantity;
    bid_more = bid_qty > ask_qty;
    ask_more = ask_qty > bid_qty;
    match_d  = '0;
    // Crossed book with both heads present
    match_d.vld = bid_head.vld && ask_head.vld &&
                  (bid_head.head.price >= ask_head.head.price);
    match_d.bid_uid = bid_head.head.uid;
    match_d.ask_uid = ask_head.head.uid;
    // Smaller side fills completely
    match_d.quantity     = bid_more ? ask_qty : bid_qty;
    match_d.bid_consumed = ~bid_more;
    match_d.ask_consumed = ~ask_more;
    // Larger side keeps the difference, zero on equal
    if (bid_more) begin
      match_d.remainder = bid_qty - ask_qty;
    end else begin
      match_d.remainder = ask_qty - bid_qty;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else if (capture) begin
      vld_q <= match_d.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      data_q <= match_d;
    end
  end

  always_comb begin
    match     = data_q;
    match.vld = vld_q;
  end

  a_match_consumes: assert property (@(posedge clk) disable iff (rst)
    match.vld |-> (match.bid_consumed || match.ask_consumed));

endmodule

// ==== design/ob_cntrl.sv ====
`timescale 1ns/100ps
`include "ob_params.svh"

module ob_cntrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_vld,
  input  ob_pkg::cmd_t       cmd,
  output logic               cmd_pop,
  input  logic               rsp_full,
  output logic               rsp_vld,
  output ob_pkg::rsp_t       rsp,
  input  ob_pkg::book_head_t bid_head,
  output logic               bid_insert,
  output ob_pkg::entry_t     bid_insert_entry,
  output logic               bid_pop,
  output logic               bid_update,
  output ob_pkg::quantity_t  bid_update_qty,
  input  ob_pkg::book_head_t ask_head,
  output logic               ask_insert,
  output ob_pkg::entry_t     ask_insert_entry,
  output logic               ask_pop,
  output logic               ask_update,
  output ob_pkg::quantity_t  ask_update_qty,
  output logic               match_capture,
  input  ob_pkg::match_t     match
);
  import ob_pkg::*;

  // Two-bit state, no separate done state
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ISSUE   = 2'd1,
    EXECUTE = 2'd2
  } state_t;

  state_t state_q;
  state_t state_d;

  // Single command latch
  logic   latch_vld_q;
  cmd_t   latch_q;
  logic   cmd_fetch;
  logic   cmd_consume;
  entry_t order;

  // Take a new command when the latch is free or freed this cycle
  assign cmd_fetch = cmd_vld & (~latch_vld_q | cmd_consume);
  assign cmd_pop   = cmd_fetch;

  always_ff @(posedge clk) begin
    if (rst) begin
      latch_vld_q <= 1'b0;
    end else if (cmd_fetch) begin
      latch_vld_q <= 1'b1;
    end else if (cmd_consume) begin
      latch_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fetch) begin
      latch_q <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Resting order carries the command uid
  always_comb begin
    order     = latch_q.oprand;
    order.uid = latch_q.uid;
  end

  assign bid_insert_entry = order;
  assign ask_insert_entry = order;

  // Surviving head takes the remainder
  assign bid_update_qty = match.remainder;
  assign ask_update_qty = match.remainder;

  always_comb begin
    state_d       = state_q;
    cmd_consume   = 1'b0;
    rsp_vld       = 1'b0;
    rsp           = '0;
    bid_insert    = 1'b0;
    bid_pop       = 1'b0;
    bid_update    = 1'b0;
    ask_insert    = 1'b0;
    ask_pop       = 1'b0;
    ask_update    = 1'b0;
    match_capture = 1'b0;
    // Full response path stalls everything
    if (!rsp_full) begin
      case (state_q)
        IDLE: begin
          if (latch_vld_q) begin
            // Most commands answer Okay and retire at once
            rsp_vld     = 1'b1;
            rsp.uid     = latch_q.uid;
            rsp.status  = S_Okay;
            cmd_consume = 1'b1;
            case (latch_q.opcode)
              Op_Nop: begin
              end
              Op_QryBidAsk: begin
                rsp.result.qrybidask.bid = bid_head.head.price;
                rsp.result.qrybidask.ask = ask_head.head.price;
                // Spread only defined with both sides present
                if (!(bid_head.vld && ask_head.vld)) begin
                  rsp.status = S_Bad;
                end
              end
              Op_Buy: begin
                if (bid_head.full) begin
                  rsp.status = S_Full;
                end else begin
                  // Command stays latched until matching ends
                  bid_insert  = 1'b1;
                  cmd_consume = 1'b0;
                  state_d     = ISSUE;
                end
              end
              Op_Sell: begin
                if (ask_head.full) begin
                  rsp.status = S_Full;
                end else begin
                  ask_insert  = 1'b1;
                  cmd_consume = 1'b0;
                  state_d     = ISSUE;
                end
              end
              Op_PopTopBid: begin
                bid_pop = bid_head.vld;
                if (bid_head.vld) begin
                  rsp.result.poptop = bid_head.head;
                end else begin
                  rsp.status = S_BadPop;
                end
              end
              Op_PopTopAsk: begin
                ask_pop = ask_head.vld;
                if (ask_head.vld) begin
                  rsp.result.poptop = ask_head.head;
                end else begin
                  rsp.status = S_BadPop;
                end
              end
              // Unknown opcode
              default: rsp.status = S_Bad;
            endcase
          end
        end
        ISSUE: begin
          // Book heads settled, register the comparison
          match_capture = 1'b1;
          state_d       = EXECUTE;
        end
        EXECUTE: begin
          if (match.vld) begin
            rsp_vld                   = 1'b1;
            rsp.uid                   = `OB_TRADE_UID;
            rsp.status                = S_Okay;
            rsp.result.trade.bid_uid  = match.bid_uid;
            rsp.result.trade.ask_uid  = match.ask_uid;
            rsp.result.trade.quantity = match.quantity;
            // Consumed heads leave, the other keeps the remainder
            bid_pop    = match.bid_consumed;
            ask_pop    = match.ask_consumed;
            bid_update = ~match.bid_consumed;
            ask_update = ~match.ask_consumed;
            state_d    = ISSUE;
          end else begin
            // Book no longer crosses
            cmd_consume = 1'b1;
            state_d     = IDLE;
          end
        end
        default: state_d = IDLE;
      endcase
    end
  end

  a_rsp_not_full: assert property (@(posedge clk) disable iff (rst)
    rsp_vld |-> !rsp_full);

  // Head full flag comes from the book itself
  a_no_insert_full: assert property (@(posedge clk) disable iff (rst)
    (bid_insert |-> !bid_head.full) and (ask_insert |-> !ask_head.full));

endmodule

// ==== design/ob_top.sv ====
`timescale 1ns/100ps

module ob_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          cmd_vld,
  input  ob_pkg::cmd_t  cmd,
  output logic          cmd_pop,
  input  logic          rsp_full,
  output logic          rsp_vld,
  output ob_pkg::rsp_t  rsp
);
  import ob_pkg::*;

  // Bid side control and head
  book_head_t bid_head;
  logic       bid_insert;
  entry_t     bid_insert_entry;
  logic       bid_pop;
  logic       bid_update;
  quantity_t  bid_update_qty;

  // Ask side control and head
  book_head_t ask_head;
  logic       ask_insert;
  entry_t     ask_insert_entry;
  logic       ask_pop;
  logic       ask_update;
  quantity_t  ask_update_qty;

  // Matcher handshake
  logic       match_capture;
  match_t     match;

  ob_cntrl cntrl_i (
    .clk              (clk),
    .rst              (rst),
    .cmd_vld          (cmd_vld),
    .cmd              (cmd),
    .cmd_pop          (cmd_pop),
    .rsp_full         (rsp_full),
    .rsp_vld          (rsp_vld),
    .rsp              (rsp),
    .bid_head         (bid_head),
    .bid_insert       (bid_insert),
    .bid_insert_entry (bid_insert_entry),
    .bid_pop          (bid_pop),
    .bid_update       (bid_update),
    .bid_update_qty   (bid_update_qty),
    .ask_head         (ask_head),
    .ask_insert       (ask_insert),
    .ask_insert_entry (ask_insert_entry),
    .ask_pop          (ask_pop),
    .ask_update       (ask_update),
    .ask_update_qty   (ask_update_qty),
    .match_capture    (match_capture),
    .match            (match)
  );

  ob_match match_i (
    .clk      (clk),
    .rst      (rst),
    .bid_head (bid_head),
    .ask_head (ask_head),
    .capture  (match_capture),
    .match    (match)
  );

  // Bids best first means highest price at the head
  ob_book_side #(.IS_BID(1'b1)) bid_book_i (
    .clk          (clk),
    .rst          (rst),
    .insert       (bid_insert),
    .insert_entry (bid_insert_entry),
    .pop          (bid_pop),
    .update       (bid_update),
    .update_qty   (bid_update_qty),
    .head         (bid_head)
  );

  // Asks lowest price at the head
  ob_book_side #(.IS_BID(1'b0)) ask_book_i (
    .clk          (clk),
    .rst          (rst),
    .insert       (ask_insert),
    .insert_entry (ask_insert_entry),
    .pop          (ask_pop),
    .update       (ask_update),
    .update_qty   (ask_update_qty),
    .head         (ask_head)
  );

endmodule

// ==== verif/ob_tb.sv ====
`timescale 1ns/100ps
`include "ob_params.svh"

module ob_tb;
  import ob_pkg::*;

  // Cycles allowed for any single wait
  localparam int TIMEOUT = 200;

  logic clk;
  logic rst;
  logic cmd_vld;
  cmd_t cmd;
  logic cmd_pop;
  logic rsp_full;
  logic rsp_vld;
  rsp_t rsp;

  // Captured responses, oldest first
  rsp_t        rsp_q[$];
  int          pop_count;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng_state;

  ob_top ob_top_i (
    .clk      (clk),
    .rst      (rst),
    .cmd_vld  (cmd_vld),
    .cmd      (cmd),
    .cmd_pop  (cmd_pop),
    .rsp_full (rsp_full),
    .rsp_vld  (rsp_vld),
    .rsp      (rsp)
  );

  always #5 clk = ~clk;

  // Command takes and responses, seen on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (cmd_vld && cmd_pop) begin
        pop_count++;
      end
      if (rsp_vld) begin
        if (rsp_full) begin
          $display("Response valid while the response path was full at %0t", $time);
          err_count++;
        end
        rsp_q.push_back(rsp);
      end
    end
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      err_count++;
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Advances the generator
  function automatic int unsigned rand_qty(input int unsigned lo, input int unsigned hi);
    rng_state = xorshift32(rng_state);
    return lo + (rng_state % (hi - lo + 1));
  endfunction

  function automatic int unsigned min_qty(input int unsigned a, input int unsigned b);
    return (a < b) ? a : b;
  endfunction

  function automatic cmd_t make_cmd(input opcode_t op, input uid_t uid,
                                    input price_t price, input quantity_t qty);
    cmd_t c;
    c                 = '0;
    c.opcode          = op;
    c.uid             = uid;
    c.oprand.price    = price;
    c.oprand.quantity = qty;
    return c;
  endfunction

  task automatic reset_dut();
    @(negedge clk);
    rst      = 1'b1;
    cmd_vld  = 1'b0;
    rsp_full = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    rsp_q.delete();
  endtask

  // Hold the command until the DUT pops it
  task automatic send_cmd(input cmd_t c);
    int start;
    int cycles;
    start  = pop_count;
    cycles = 0;
    @(negedge clk);
    cmd     = c;
    cmd_vld = 1'b1;
    while (pop_count == start && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    cmd_vld = 1'b0;
    if (pop_count == start) begin
      $display("Timeout at %0t: command with uid %0d was never taken", $time, c.uid);
      err_count++;
    end
  endtask

  task automatic wait_rsps(input int n, input string what);
    int cycles;
    cycles = 0;
    while (rsp_q.size() < n && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (rsp_q.size() < n) begin
      $display("Timeout at %0t: only %0d of %0d responses for %s", $time, rsp_q.size(), n,
               what);
      err_count++;
    end
  endtask

  // Oldest response, checked for uid and status
  task automatic expect_rsp(input uid_t uid, input status_t st, input string what,
                            output rsp_t r);
    r = '0;
    if (rsp_q.size() == 0) begin
      $display("Missing response for %s at %0t", what, $time);
      err_count++;
    end else begin
      r = rsp_q.pop_front();
      check_eq(r.uid, uid, {what, " uid"});
      check_eq(r.status, st, {what, " status"});
    end
  endtask

  task automatic expect_trade(input uid_t bid_uid, input uid_t ask_uid,
                              input quantity_t qty, input string what);
    rsp_t r;
    expect_rsp(`OB_TRADE_UID, S_Okay, what, r);
    check_eq(r.result.trade.bid_uid, bid_uid, {what, " bid uid"});
    check_eq(r.result.trade.ask_uid, ask_uid, {what, " ask uid"});
    check_eq(r.result.trade.quantity, qty, {what, " quantity"});
  endtask

  task automatic end_test(input string name, input int errs_before);
    check_eq(rsp_q.size(), 0, {name, " leftover responses"});
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
      $display("Test %s finished with %0d errors", name, err_count - errs_before);
    end else begin
      $display("Test %s finished cleanly", name);
    end
  endtask

  task automatic nop_and_empty_book();
    int   errs;
    rsp_t r;
    reset_dut();
    errs = err_count;
    send_cmd(make_cmd(Op_Nop, 8'd1, '0, '0));
    send_cmd(make_cmd(Op_QryBidAsk, 8'd2, '0, '0));
    send_cmd(make_cmd(Op_PopTopBid, 8'd3, '0, '0));
    send_cmd(make_cmd(Op_PopTopAsk, 8'd4, '0, '0));
    wait_rsps(4, "empty book");
    expect_rsp(8'd1, S_Okay, "nop", r);
    expect_rsp(8'd2, S_Bad, "empty query", r);
    expect_rsp(8'd3, S_BadPop, "empty bid pop", r);
    expect_rsp(8'd4, S_BadPop, "empty ask pop", r);
    end_test("nop_empty", errs);
  endtask

  task automatic resting_orders();
    int   errs;
    rsp_t r;
    reset_dut();
    errs = err_count;
    send_cmd(make_cmd(Op_Buy, 8'd10, 12'd100, 10'd50));
    send_cmd(make_cmd(Op_Sell, 8'd11, 12'd120, 10'd60));
    send_cmd(make_cmd(Op_QryBidAsk, 8'd12, '0, '0));
    wait_rsps(3, "resting orders");
    // Query right behind both inserts means no trade came between
    expect_rsp(8'd10, S_Okay, "resting buy", r);
    expect_rsp(8'd11, S_Okay, "resting sell", r);
    expect_rsp(8'd12, S_Okay, "spread query", r);
    check_eq(r.result.qrybidask.bid, 100, "best bid");
    check_eq(r.result.qrybidask.ask, 120, "best ask");
    end_test("resting", errs);
  endtask

  task automatic trade_with_remainder();
    int   errs;
    rsp_t r;
    reset_dut();
    errs = err_count;
    send_cmd(make_cmd(Op_Sell, 8'd20, 12'd100, 10'd10));
    send_cmd(make_cmd(Op_Buy, 8'd21, 12'd105, 10'd25));
    send_cmd(make_cmd(Op_PopTopBid, 8'd22, '0, '0));
    wait_rsps(4, "remainder");
    expect_rsp(8'd20, S_Okay, "sell", r);
    expect_rsp(8'd21, S_Okay, "buy", r);
    expect_trade(8'd21, 8'd20, min_qty(25, 10), "single trade");
    expect_rsp(8'd22, S_Okay, "bid pop", r);
    check_eq(r.result.poptop.uid, 21, "rest bid uid");
    check_eq(r.result.poptop.price, 105, "rest bid price");
    check_eq(r.result.poptop.quantity, 25 - 10, "rest bid quantity");
    end_test("remainder", errs);
  endtask

  task automatic time_priority();
    int          errs;
    int unsigned q1;
    int unsigned q2;
    int unsigned rest;
    int unsigned t2;
    rsp_t        r;
    reset_dut();
    errs = err_count;
    q1   = rand_qty(1, 200);
    q2   = rand_qty(1, 200);
    rest = rand_qty(1, 200);
    // Buy always clears the first ask, then meets the second
    send_cmd(make_cmd(Op_Sell, 8'd30, 12'd200, q1));
    send_cmd(make_cmd(Op_Sell, 8'd31, 12'd200, q2));
    send_cmd(make_cmd(Op_Buy, 8'd32, 12'd210, q1 + rest));
    send_cmd(make_cmd(Op_PopTopBid, 8'd33, '0, '0));
    send_cmd(make_cmd(Op_PopTopAsk, 8'd34, '0, '0));
    wait_rsps(7, "priority");
    expect_rsp(8'd30, S_Okay, "first ask", r);
    expect_rsp(8'd31, S_Okay, "second ask", r);
    expect_rsp(8'd32, S_Okay, "large buy", r);
    expect_trade(8'd32, 8'd30, q1, "older ask trade");
    t2 = min_qty(rest, q2);
    expect_trade(8'd32, 8'd31, t2, "newer ask trade");
    if (rest > q2) begin
      expect_rsp(8'd33, S_Okay, "leftover bid", r);
      check_eq(r.result.poptop.uid, 32, "leftover bid uid");
      check_eq(r.result.poptop.quantity, rest - t2, "leftover bid quantity");
    end else begin
      expect_rsp(8'd33, S_BadPop, "bid consumed", r);
    end
    if (q2 > rest) begin
      expect_rsp(8'd34, S_Okay, "leftover ask", r);
      check_eq(r.result.poptop.uid, 31, "leftover ask uid");
      check_eq(r.result.poptop.quantity, q2 - t2, "leftover ask quantity");
    end else begin
      expect_rsp(8'd34, S_BadPop, "ask consumed", r);
    end
    end_test("priority", errs);
  endtask

  task automatic full_book();
    int     errs;
    price_t prices[`OB_BOOK_DEPTH];
    price_t best;
    rsp_t   r;
    reset_dut();
    errs = err_count;
    best = '0;
    for (int i = 0; i < `OB_BOOK_DEPTH; i++) begin
      prices[i] = 12'd10 + 12'((i * 7) % 5) * 12'd10;
      if (prices[i] > best) begin
        best = prices[i];
      end
      send_cmd(make_cmd(Op_Buy, 8'd40 + 8'(i), prices[i], 10'd5));
    end
    send_cmd(make_cmd(Op_Buy, 8'd60, best + 12'd1, 10'd5));
    send_cmd(make_cmd(Op_PopTopBid, 8'd61, '0, '0));
    wait_rsps(`OB_BOOK_DEPTH + 2, "full book");
    for (int i = 0; i < `OB_BOOK_DEPTH; i++) begin
      expect_rsp(8'd40 + 8'(i), S_Okay, "filling bid", r);
    end
    // Refused order must not reach the head
    expect_rsp(8'd60, S_Full, "overflow bid", r);
    expect_rsp(8'd61, S_Okay, "best bid pop", r);
    check_eq(r.result.poptop.price, best, "best bid price");
    end_test("full", errs);
  endtask

  task automatic back_pressure();
    int          errs;
    int unsigned left;
    int unsigned t1;
    int unsigned t2;
    rsp_t        r;
    reset_dut();
    errs = err_count;
    send_cmd(make_cmd(Op_Sell, 8'd50, 12'd300, 10'd20));
    send_cmd(make_cmd(Op_Sell, 8'd51, 12'd300, 10'd30));
    // Nop answers only after the second ask is done matching
    send_cmd(make_cmd(Op_Nop, 8'd54, '0, '0));
    wait_rsps(3, "backpressure setup");
    expect_rsp(8'd50, S_Okay, "bp first ask", r);
    expect_rsp(8'd51, S_Okay, "bp second ask", r);
    expect_rsp(8'd54, S_Okay, "bp idle nop", r);
    rsp_full = 1'b1;
    send_cmd(make_cmd(Op_Buy, 8'd52, 12'd310, 10'd40));
    repeat (6) @(negedge clk);
    check_eq(rsp_q.size(), 0, "responses while full");
    rsp_full = 1'b0;
    wait_rsps(1, "backpressure release");
    // Stall again between the Okay and the trades
    rsp_full = 1'b1;
    repeat (4) @(negedge clk);
    check_eq(rsp_q.size(), 1, "responses during second stall");
    rsp_full = 1'b0;
    wait_rsps(3, "backpressure trades");
    left = 40;
    t1   = min_qty(left, 20);
    left = left - t1;
    t2   = min_qty(left, 30);
    expect_rsp(8'd52, S_Okay, "bp buy", r);
    expect_trade(8'd52, 8'd50, t1, "bp first trade");
    expect_trade(8'd52, 8'd51, t2, "bp second trade");
    send_cmd(make_cmd(Op_PopTopAsk, 8'd53, '0, '0));
    wait_rsps(1, "bp ask pop");
    expect_rsp(8'd53, S_Okay, "bp ask pop", r);
    check_eq(r.result.poptop.uid, 51, "bp leftover ask uid");
    check_eq(r.result.poptop.quantity, 30 - t2, "bp leftover ask quantity");
    end_test("backpressure", errs);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    cmd_vld      = 1'b0;
    cmd          = '0;
    rsp_full     = 1'b0;
    pop_count    = 0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = 32'd81017;
    nop_and_empty_book();
    resting_orders();
    trade_with_remainder();
    time_priority();
    full_book();
    back_pressure();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+common
common/ob_pkg.sv
book/ob_book_side.sv
design/ob_match.sv
design/ob_cntrl.sv
design/ob_top.sv
verif/ob_tb.sv
